// ==== vlog.f ====
hdl/reconfig_pkg.sv
hdl/mgmt_bus_if.sv
hdl/store_write_if.sv
hdl/reconfig_request_port.sv
hdl/reconfig_mgmt_write.sv
hdl/reconfig_csr_block.sv
hdl/xcvr_setting_store.sv
hdl/reconfig_subsys_top.sv
testbench/reconfig_assert.sv
testbench/reconfig_tb.sv

// ==== testbench/reconfig_tb.sv ====
module reconfig_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import reconfig_pkg::*;

	localparam int N_REQ    = 25;	// requests issued over all tests
	localparam int WD_CYCLES = N_REQ * 40 + 400;	// plus margin for reads and hold

	logic clk = 1'b0;
	logic reset, req, ack, req_mif_mode, rd_mode;
	lch_t req_lch, rd_lch;
	feat_off_t req_offset, rd_offset;
	mgmt_data_t req_data, rd_data;

	mgmt_data_t ref_mem [16][64];	// expected store contents
	logic [15:0] ref_mode;	// expected mode bit per channel
	int checks = 0;
	int errors = 0;

	reconfig_subsys_top dut_i (.*);

	always #10 clk = ~clk;

	// **********************************************************************
	// compare tasks
	// **********************************************************************
	task automatic check_data(input mgmt_data_t got, input mgmt_data_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t ns: %s data %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_mode(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// sample at negedge, clear of the posedge updates
	task automatic wait_ack(input logic level);
		for (int i = 0; i < 100; i++) begin
			@(negedge clk);
			if (ack === level) return;
		end
		errors++;
		$display("handshake stuck: ack never went to %b at %0t ns", level, $time);
	endtask

	task automatic do_request(input lch_t l, input feat_off_t o,
			input mgmt_data_t d, input logic m);
		@(posedge clk);
		#1;
		{req_lch, req_offset, req_data, req_mif_mode} = {l, o, d, m};
		req = 1'b1;
		wait_ack(1'b1);
		ref_mem[l][o] = d;	// committed once ack is up
		ref_mode[l]   = m;
		@(posedge clk);
		#1 req = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic read_check(input lch_t l, input feat_off_t o, input string what);
		@(posedge clk);
		#1;
		rd_lch    = l;
		rd_offset = o;
		@(negedge clk);
		check_data(rd_data, ref_mem[l][o], what);
		check_mode(rd_mode, ref_mode[l], what);
	endtask

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before) $display("%s: ok", name);
		else $display("%s: %0d errors", name, errors - err_before);
	endtask

	// **********************************************************************
	// directed tests
	// **********************************************************************
	task automatic after_reset();
		int e = errors;
		check_mode(ack, 1'b0, "ack after reset");
		read_check(0, 0, "reset 0/0");
		read_check(15, 63, "reset 15/63");
		read_check(5, 17, "reset 5/17");
		report_test("after_reset", e);
	endtask

	task automatic single_mode0();
		int e = errors;
		do_request(3, 12, 32'hCAFE_0123, 1'b0);
		read_check(3, 12, "mode0 3/12");
		report_test("single_mode0", e);
	endtask

	task automatic mif_mode1();
		int e = errors;
		do_request(7, 33, $urandom, 1'b1);
		read_check(7, 33, "mode1 7/33");
		do_request(7, 34, $urandom, 1'b0);	// same channel, mode bit clears
		read_check(7, 34, "mode0 7/34");
		report_test("mif_mode1", e);
	endtask

	task automatic random_ops();
		int e = errors;
		lch_t l;
		feat_off_t o;
		for (int n = 0; n < 20; n++) begin
			l = lch_t'($urandom);
			o = feat_off_t'($urandom);
			do_request(l, o, $urandom, 1'($urandom % 2));
			read_check(l, o, "random op");
			read_check(lch_t'($urandom), feat_off_t'($urandom), "random probe");	// mostly untouched
		end
		report_test("random_ops", e);
	endtask

	task automatic handshake_hold();
		int e = errors;
		logic dropped = 1'b0;
		@(posedge clk);
		#1;
		{req_lch, req_offset, req_data, req_mif_mode} = {4'd2, 6'd5, 32'hA5A5_0001, 1'b0};
		req = 1'b1;
		wait_ack(1'b1);
		ref_mem[2][5] = 32'hA5A5_0001;
		ref_mode[2]   = 1'b0;
		for (int i = 0; i < 30; i++) begin	// req held, fields wander
			@(posedge clk);
			#1;
			{req_lch, req_offset, req_data, req_mif_mode} = {4'd2, 6'd5, $urandom, 1'b1};
			@(negedge clk);
			if (!ack) dropped = 1'b1;
		end
		check_mode(dropped, 1'b0, "ack drop during held req");
		read_check(2, 5, "held req 2/5");
		@(posedge clk);
		#1 req = 1'b0;
		wait_ack(1'b0);
		read_check(2, 5, "after release 2/5");
		do_request(2, 5, 32'h5A5A_0002, 1'b1);	// next request now lands
		read_check(2, 5, "next req 2/5");
		report_test("handshake_hold", e);
	endtask

	// **********************************************************************
	// run control
	// **********************************************************************
	initial begin
		#(WD_CYCLES * 20);
		$display("timeout: the run did not complete within %0d cycles", WD_CYCLES);
		$display("Checks failed");
		$finish;
	end

	initial begin
		void'($urandom(52));
		{req, req_lch, req_offset, req_data, req_mif_mode} = '0;
		rd_lch    = '0;
		rd_offset = '0;
		ref_mode  = '0;
		for (int c = 0; c < 16; c++)
			for (int o = 0; o < 64; o++)
				ref_mem[c][o] = '0;
		reset = 1'b1;
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;
		after_reset();
		single_mode0();
		mif_mode1();
		random_ops();
		handshake_hold();
		// failures flagged by the bound assertions
		errors += dut_i.u_mgmt_write.bus_rules_i.fail_cnt;
		errors += dut_i.u_req_port.handshake_rules_i.fail_cnt;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== testbench/reconfig_assert.sv ====
module reconfig_assert (
	input logic                     clk,
	input logic                     reset,
	input logic                     write,
	input logic                     waitrequest,
	input logic                     busy,
	input reconfig_pkg::mgmt_addr_t address,
	input reconfig_pkg::mgmt_data_t writedata,
	input logic                     req,
	input logic                     ack
);
	timeunit 1ns;
	timeprecision 100ps;
	import reconfig_pkg::*;

	int fail_cnt = 0;	// failed assertions in this instance

	// a stalled write keeps its address and payload
	hold_on_stall: assert property (@(posedge clk) disable iff (reset)
		write && waitrequest |=> write && $stable(address) && $stable(writedata))
		else begin
			$error("stalled write changed address or data");
			fail_cnt++;
		end

	start_not_busy: assert property (@(posedge clk) disable iff (reset)
		write && address == ADDR_CS && writedata[CS_START_BIT] |-> !busy)
		else begin
			$error("start write issued while controller busy");
			fail_cnt++;
		end

	// four-phase, ack drops only once req is seen low
	ack_after_req: assert property (@(posedge clk) disable iff (reset)
		$fell(ack) |-> $past(!req))
		else begin
			$error("ack fell while req still high");
			fail_cnt++;
		end

endmodule

// bus rules on the sequencer, handshake rule on the request port
bind reconfig_mgmt_write reconfig_assert bus_rules_i (
	.clk(clk), .reset(reset), .write(bus.write), .waitrequest(bus.waitrequest),
	.busy(bus.busy), .address(bus.address), .writedata(bus.writedata),
	.req(1'b1), .ack(1'b0)
);

bind reconfig_request_port reconfig_assert handshake_rules_i (
	.clk(clk), .reset(reset), .write(1'b0), .waitrequest(1'b0), .busy(1'b0),
	.address('0), .writedata('0), .req(req), .ack(ack)
);

// ==== hdl/reconfig_subsys_top.sv ====
module reconfig_subsys_top (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    req,
	output logic                    ack,
	input  reconfig_pkg::lch_t       req_lch,
	input  reconfig_pkg::feat_off_t  req_offset,
	input  reconfig_pkg::mgmt_data_t req_data,
	input  logic                    req_mif_mode,
	input  reconfig_pkg::lch_t       rd_lch,
	input  reconfig_pkg::feat_off_t  rd_offset,
	output reconfig_pkg::mgmt_data_t rd_data,
	output logic                    rd_mode
);
	import reconfig_pkg::*;

	// latched op from the request port to the sequencer
	logic       op_valid;
	lch_t       op_lch;
	feat_off_t  op_offset;
	mgmt_data_t op_data;
	logic       op_mif_mode;
	logic       op_done;

	mgmt_bus_if    bus_if ();	// sequencer -> controller registers
	store_write_if store_if ();	// controller -> setting store

	reconfig_request_port u_req_port (
		.clk, .reset,
		.req, .req_lch, .req_offset, .req_data, .req_mif_mode, .ack,
		.op_valid, .op_lch, .op_offset, .op_data, .op_mif_mode, .op_done
	);

	reconfig_mgmt_write u_mgmt_write (
		.clk, .reset,
		.op_valid, .op_lch, .op_offset, .op_data, .op_mif_mode, .op_done,
		.bus (bus_if.master)
	);

	reconfig_csr_block u_csr (
		.clk, .reset,
		.bus   (bus_if.slave),
		.store (store_if.source)
	);

	xcvr_setting_store u_store (
		.clk, .reset,
		.store (store_if.sink),
		.rd_lch, .rd_offset, .rd_data, .rd_mode
	);

endmodule

// ==== hdl/xcvr_setting_store.sv ====
module xcvr_setting_store (
	input  logic                    clk,
	input  logic                    reset,
	store_write_if.sink             store,
	input  reconfig_pkg::lch_t       rd_lch,
	input  reconfig_pkg::feat_off_t  rd_offset,
	output reconfig_pkg::mgmt_data_t rd_data,
	output logic                    rd_mode
);
	import reconfig_pkg::*;

	localparam int N_LCH = 2 ** $bits(lch_t);		// 16 channels
	localparam int N_OFF = 2 ** $bits(feat_off_t);	// 64 settings each

	mgmt_data_t       mem [N_LCH][N_OFF];	// applied settings
	logic [N_LCH-1:0] mode_vec;			// mode of last op per channel

	// **********************************************************************
	// commit port
	// **********************************************************************
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			mode_vec <= '0;
			for (int c = 0; c < N_LCH; c++) begin
				for (int o = 0; o < N_OFF; o++)
					mem[c][o] <= '0;	// readback is zero out of reset
			end
		end else if (store.commit) begin
			mem[store.lch][store.offset] <= store.data;
			mode_vec[store.lch]          <= store.mif_mode;
		end
	end

	// readback, purely combinational
	assign rd_data = mem[rd_lch][rd_offset];
	assign rd_mode = mode_vec[rd_lch];

endmodule

// ==== hdl/reconfig_csr_block.sv ====
module reconfig_csr_block (
	input  logic         clk,
	input  logic         reset,
	mgmt_bus_if.slave    bus,
	store_write_if.source store
);
	import reconfig_pkg::*;

	logic                  wait_phase;	// first cycle of the current write seen
	logic                  wr_take;		// write completes this cycle
	logic                  wr_live;		// completed write that is decoded
	logic [BUSY_CNT_W-1:0] busy_cnt;
	lch_t                  lch_reg;
	feat_off_t             offset_reg;
	mgmt_data_t            data_reg;
	logic                  mode_reg;		// mif mode bit from last cs write

	// **********************************************************************
	// one wait state per write
	// **********************************************************************
	assign bus.waitrequest = bus.write && !wait_phase;
	assign wr_take         = bus.write && !bus.waitrequest;
	assign wr_live         = wr_take && !bus.busy;	// dropped while busy

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			wait_phase <= 1'b0;
		else
			wait_phase <= bus.write && bus.waitrequest;	// clears on completion
	end

	// register decode, payload only
	always_ff @(posedge clk) begin
		if (wr_live) begin
			case (bus.address)
				ADDR_LCH:    lch_reg    <= lch_t'(bus.writedata);
				ADDR_OFFSET: offset_reg <= feat_off_t'(bus.writedata);
				ADDR_DATA:   data_reg   <= bus.writedata;
				default:     ;	// cs handled below, others unmapped
			endcase
		end
	end

	// **********************************************************************
	// control/status, busy timer
	// **********************************************************************
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy_cnt <= '0;
			mode_reg <= 1'b0;
		end else if (wr_live && bus.address == ADDR_CS) begin
			mode_reg <= bus.writedata[CS_MIF_MODE1_BIT];	// mode 0 start clears it
			if (bus.writedata[CS_START_BIT])
				busy_cnt <= BUSY_CNT_W'(BUSY_CYCLES);
		end else if (busy_cnt != '0) begin
			busy_cnt <= busy_cnt - 1'b1;
		end
	end

	assign bus.busy = (busy_cnt != '0);

	// commit in the last busy cycle, store updated before busy falls
	assign store.commit   = (busy_cnt == BUSY_CNT_W'(1));
	assign store.lch      = lch_reg;
	assign store.offset   = offset_reg;
	assign store.data     = data_reg;
	assign store.mif_mode = mode_reg;

endmodule

// ==== hdl/reconfig_mgmt_write.sv ====
module reconfig_mgmt_write (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    op_valid,	// held until op_done
	input  reconfig_pkg::lch_t       op_lch,
	input  reconfig_pkg::feat_off_t  op_offset,
	input  reconfig_pkg::mgmt_data_t op_data,
	input  logic                    op_mif_mode,
	output logic                    op_done,
	mgmt_bus_if.master              bus
);
	import reconfig_pkg::*;

	seq_state_t state;
	logic       accept;		// write completes this cycle
	mgmt_data_t start_word;	// cs word with start bit

	assign accept = bus.write && !bus.waitrequest;

	always_comb begin
		start_word                   = '0;
		start_word[CS_START_BIT]     = 1'b1;
		start_word[CS_MIF_MODE1_BIT] = op_mif_mode;	// mode bit rides along in mode 1
	end

	// **********************************************************************
	// sequencing, one state per write, advance only on accept
	// **********************************************************************
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE:
					if (op_valid && !bus.busy) state <= S_WR_CH;
				S_WR_CH:
					if (accept) state <= op_mif_mode ? S_WR_MIF : S_WR_OFFSET;
				S_WR_MIF:       if (accept) state <= S_WR_OFFSET;
				S_WR_OFFSET:    if (accept) state <= S_WR_DATA;
				S_WR_DATA:      if (accept) state <= S_WR_START;
				S_WR_START:     if (accept) state <= S_WAIT_BUSY_HI;
				S_WAIT_BUSY_HI: if (bus.busy) state <= S_WAIT_BUSY_LO;	// controller took it
				S_WAIT_BUSY_LO: if (!bus.busy) state <= S_DONE;		// setting committed
				S_DONE:         state <= S_IDLE;
				default:        state <= S_IDLE;
			endcase
		end
	end

	// bus drive decoded from state, op fields are stable while op_valid
	always_comb begin
		bus.write     = 1'b1;
		bus.address   = ADDR_CS;
		bus.writedata = '0;
		case (state)
			S_WR_CH: begin
				bus.address   = ADDR_LCH;
				bus.writedata = mgmt_data_t'(op_lch);
			end
			S_WR_MIF:    bus.writedata[CS_MIF_MODE1_BIT] = 1'b1;	// cs word, mode 1 bit only
			S_WR_OFFSET: begin
				bus.address   = ADDR_OFFSET;
				bus.writedata = mgmt_data_t'(op_offset);
			end
			S_WR_DATA: begin
				bus.address   = ADDR_DATA;
				bus.writedata = op_data;
			end
			S_WR_START:  bus.writedata = start_word;
			default:     bus.write = 1'b0;	// no transfer outside write states
		endcase
	end

	assign op_done = (state == S_DONE);

endmodule

// ==== hdl/reconfig_request_port.sv ====
module reconfig_request_port (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   req,		// four-phase request
	input  reconfig_pkg::lch_t      req_lch,
	input  reconfig_pkg::feat_off_t req_offset,
	input  reconfig_pkg::mgmt_data_t req_data,
	input  logic                   req_mif_mode,
	output logic                   ack,
	output logic                   op_valid,	// level to the sequencer
	output reconfig_pkg::lch_t      op_lch,
	output reconfig_pkg::feat_off_t op_offset,
	output reconfig_pkg::mgmt_data_t op_data,
	output logic                   op_mif_mode,
	input  logic                   op_done		// pulse from the sequencer
);
	import reconfig_pkg::*;

	typedef enum logic [1:0] {
		RP_WAIT_REQ,	// ack low, looking for req
		RP_PENDING,		// op handed to the sequencer
		RP_ACK_HELD		// ack high until req drops
	} rp_state_t;

	rp_state_t state;
	logic      accept;

	assign accept = (state == RP_WAIT_REQ) && req;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= RP_WAIT_REQ;
		end else begin
			case (state)
				RP_WAIT_REQ: if (req) state <= RP_PENDING;
				RP_PENDING:  if (op_done) state <= RP_ACK_HELD;
				RP_ACK_HELD: if (!req) state <= RP_WAIT_REQ;	// ack falls next cycle
				default:     state <= RP_WAIT_REQ;
			endcase
		end
	end

	// field latch, frozen while the op is in flight and ack is up
	always_ff @(posedge clk) begin
		if (accept) begin
			op_lch      <= req_lch;
			op_offset   <= req_offset;
			op_data     <= req_data;
			op_mif_mode <= req_mif_mode;
		end
	end

	assign op_valid = (state == RP_PENDING);
	assign ack      = (state == RP_ACK_HELD);

endmodule

// ==== hdl/store_write_if.sv ====
interface store_write_if;
	import reconfig_pkg::*;

	logic       commit;	// one cycle write strobe
	lch_t       lch;
	feat_off_t  offset;
	mgmt_data_t data;
	logic       mif_mode;	// mode of the committed operation

	modport source (
		output commit, lch, offset, data, mif_mode
	);

	modport sink (
		input  commit, lch, offset, data, mif_mode
	);

endinterface

// ==== hdl/mgmt_bus_if.sv ====
interface mgmt_bus_if;
	import reconfig_pkg::*;

	mgmt_addr_t address;	// register select
	mgmt_data_t writedata;
	logic       write;		// held until accepted
	logic       waitrequest;	// slave stall, high in first write cycle
	logic       busy;		// controller is applying a setting

	// sequencer side
	modport master (
		output address,
		output writedata,
		output write,
		input  waitrequest,
		input  busy
	);

	// register block side
	modport slave (
		input  address,
		input  writedata,
		input  write,
		output waitrequest,
		output busy
	);

endinterface

// ==== hdl/reconfig_pkg.sv ====
package reconfig_pkg;

	// **********************************************************************
	// widths that carry a meaning
	// **********************************************************************
	typedef logic [6:0]  mgmt_addr_t;	// management bus word address
	typedef logic [31:0] mgmt_data_t;	// bus write word / stored setting
	typedef logic [3:0]  lch_t;		// logical channel, 16 channels
	typedef logic [5:0]  feat_off_t;	// feature offset, 64 per channel

	// register map of the reconfig controller
	localparam mgmt_addr_t ADDR_LCH    = 7'h38;	// logical channel number
	localparam mgmt_addr_t ADDR_CS     = 7'h3A;	// control / status
	localparam mgmt_addr_t ADDR_OFFSET = 7'h3B;	// feature offset
	localparam mgmt_addr_t ADDR_DATA   = 7'h3C;	// setting data

	// control/status word bits
	localparam int CS_START_BIT     = 0;	// kicks off the reconfig
	localparam int CS_MIF_MODE1_BIT = 2;	// MIF streamer mode 1

	// controller busy time after a start, in clk cycles
	localparam int BUSY_CYCLES = 8;
	localparam int BUSY_CNT_W  = $clog2(BUSY_CYCLES + 1);

	// write sequencer states, one per bus write plus the busy wait
	typedef enum logic [3:0] {
		S_IDLE,
		S_WR_CH,		// logical channel
		S_WR_MIF,		// cs with mode 1 bit, mode 1 only
		S_WR_OFFSET,
		S_WR_DATA,
		S_WR_START,		// cs with start bit
		S_WAIT_BUSY_HI,
		S_WAIT_BUSY_LO,
		S_DONE
	} seq_state_t;

endpackage
